/* build.f */
verilog/isa_pkg.sv
verilog/ctrl_pkg.sv
verilog/main_control.sv
verilog/imm_gen.sv
verilog/id_ex_stage.sv
verilog/decode_unit.sv
dv/decode_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compiles the decode stage testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
TOP=decode_unit_tb

verilator --binary --assert --timing -j 0 \
   -f build.f \
   --top-module "$TOP" \
   -Mdir "$OBJ_DIR"
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit "$status"
fi

"./$OBJ_DIR/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit "$status"
fi

echo "Simulation ended with status 0"
exit 0

/* dv/decode_unit_tb.sv */
module decode_unit_tb;

   import isa_pkg::*;
   import ctrl_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 8;
   localparam int N_DIRECTED   = 8;
   localparam int N_RANDOM     = 600;
   // Twice the nominal run length leaves room for the drain cycles
   localparam int WATCHDOG_TIME = (RESET_CYCLES + N_DIRECTED + N_RANDOM + 16) * CLK_PERIOD * 2;

   logic              clk;
   logic              arst_n;
   logic              in_valid;
   logic              stall;
   logic              flush;
   logic [XLEN-1:0]   instr;
   logic              out_valid;
   logic              illegal_out;
   logic              reg_write_out;
   logic              mem_read_out;
   logic              mem_write_out;
   logic              mem_to_reg_out;
   logic              alu_src_out;
   logic              branch_out;
   logic              jump_out;
   alu_op_e           alu_op;
   logic [XLEN-1:0]   imm_out;
   logic [REG_W-1:0]  rs1_out;
   logic [REG_W-1:0]  rs2_out;
   logic [REG_W-1:0]  rd_out;

   // Reference slot that is one entry deep like the stage register
   logic              exp_valid;
   logic              exp_illegal;
   logic [6:0]        exp_ctrl;
   alu_op_e           exp_alu_op;
   logic [XLEN-1:0]   exp_imm;
   logic [REG_W-1:0]  exp_rs1;
   logic [REG_W-1:0]  exp_rs2;
   logic [REG_W-1:0]  exp_rd;
   logic [7:0]        dec;
   logic [31:0]       lfsr_state;
   int                hit_stall = 0;
   int                hit_flush_stall = 0;
   int                hit_idle = 0;
   int                hit_illegal = 0;

   decode_unit dut0
   (
      .clk            (clk),
      .arst_n         (arst_n),
      .in_valid       (in_valid),
      .stall          (stall),
      .flush          (flush),
      .instr          (instr),
      .out_valid      (out_valid),
      .illegal_out    (illegal_out),
      .reg_write_out  (reg_write_out),
      .mem_read_out   (mem_read_out),
      .mem_write_out  (mem_write_out),
      .mem_to_reg_out (mem_to_reg_out),
      .alu_src_out    (alu_src_out),
      .branch_out     (branch_out),
      .jump_out       (jump_out),
      .alu_op         (alu_op),
      .imm_out        (imm_out),
      .rs1_out        (rs1_out),
      .rs2_out        (rs2_out),
      .rd_out         (rd_out)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Control table packed as {illegal, reg_write, mem_read, mem_write, mem_to_reg, alu_src,
   // branch, jump}
   function automatic logic [7:0] ref_ctrl(input logic [6:0] opc);
      case (opc)
         OPC_OP:     return 8'b0100_0000;
         OPC_OP_IMM: return 8'b0100_0100;
         OPC_LOAD:   return 8'b0110_1100;
         OPC_STORE:  return 8'b0001_0100;
         OPC_BRANCH: return 8'b0000_0010;
         OPC_JALR:   return 8'b0100_0101;
         default:    return 8'b1000_0000;
      endcase
   endfunction

   // Immediates are assembled straight from raw word bit positions
   function automatic logic [XLEN-1:0] ref_imm(input logic [31:0] w);
      case (w[6:0])
         OPC_OP_IMM, OPC_LOAD, OPC_JALR: return {{20{w[31]}}, w[31:20]};
         OPC_STORE:  return {{20{w[31]}}, w[31:25], w[11:7]};
         OPC_BRANCH: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
         default:    return '0;
      endcase
   endfunction

   function automatic alu_op_e ref_alu_op(input logic [31:0] w);
      logic alt;
      alt = (w[31:25] == F7_ALT);
      if (w[6:0] == OPC_BRANCH)
      begin
         // BEQ and BNE subtract, BLT and BGE compare signed, the rest unsigned
         case (w[14:12])
            3'b000, 3'b001: return SUB;
            3'b100, 3'b101: return SLT;
            default:        return SLTU;
         endcase
      end
      if (w[6:0] != OPC_OP && w[6:0] != OPC_OP_IMM)
         return ADD;
      case (w[14:12])
         F3_ADD:  return (w[6:0] == OPC_OP && alt) ? SUB : ADD;
         F3_SLL:  return SLL;
         F3_SLT:  return SLT;
         F3_SLTU: return SLTU;
         F3_XOR:  return XOR;
         F3_SR:   return alt ? SRA : SRL;
         F3_OR:   return OR;
         default: return AND;
      endcase
   endfunction

   // Galois form that shifts right and feeds back into the tap positions
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         val = {val[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // Mostly supported opcodes and about one word in five with a random opcode
   task automatic make_instr(output logic [31:0] w);
      logic [31:0] sel;
      logic [31:0] f7_sel;
      logic [31:0] body;
      logic [31:0] r_opc;
      instr_u      iw;
      rand_bits(4, sel);
      rand_bits(7, r_opc);
      rand_bits(2, f7_sel);
      rand_bits(25, body);
      iw = {body[24:0], 7'd0};
      case (sel[3:0])
         4'd0, 4'd1:       iw.r_fmt.opcode = OPC_OP;
         4'd2, 4'd3:       iw.r_fmt.opcode = OPC_OP_IMM;
         4'd4, 4'd5:       iw.r_fmt.opcode = OPC_LOAD;
         4'd6, 4'd7:       iw.r_fmt.opcode = OPC_STORE;
         4'd8, 4'd9, 4'd10: iw.r_fmt.opcode = OPC_BRANCH;
         4'd11, 4'd12:     iw.r_fmt.opcode = OPC_JALR;
         default:          iw.r_fmt.opcode = r_opc[6:0];
      endcase
      // Bias funct7 towards the two values that select ALU variants
      if (f7_sel[1:0] == 2'd0)
         iw.r_fmt.funct7 = 7'd0;
      else if (f7_sel[1:0] != 2'd3)
         iw.r_fmt.funct7 = F7_ALT;
      w = iw;
   endtask

   task automatic drive_cycle(input logic v, input logic s, input logic f,
                              input logic [31:0] w);
      @(posedge clk);
      in_valid <= v;
      stall    <= s;
      flush    <= f;
      instr    <= w;
   endtask

   task automatic check_failed(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
      $display("ERROR %s: expected %h, actual %h", name, exp_v, act_v);
      $display("Some tests failed");
      $fatal(1);
   endtask

   assign dec = ref_ctrl(instr[6:0]);

   // Flush beats stall, stall holds, otherwise the slot takes the input
   always @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         exp_valid   <= 1'b0;
         exp_illegal <= 1'b0;
         exp_ctrl    <= '0;
      end
      else if (flush)
      begin
         exp_valid   <= 1'b0;
         exp_illegal <= 1'b0;
         exp_ctrl    <= '0;
      end
      else if (!stall)
      begin
         exp_valid   <= in_valid;
         exp_illegal <= in_valid && dec[7];
         exp_ctrl    <= (in_valid && !dec[7]) ? dec[6:0] : 7'd0;
      end
   end

   // Operand fields are only compared while the slot is valid
   always @(posedge clk)
   begin
      if (!stall)
      begin
         exp_alu_op <= ref_alu_op(instr);
         exp_imm    <= ref_imm(instr);
         exp_rs1    <= instr[19:15];
         exp_rs2    <= instr[24:20];
         exp_rd     <= instr[11:7];
      end
   end

   // Record which slot situations the stimulus reached
   always @(posedge clk)
   begin
      if (arst_n)
      begin
         if (stall && !flush && exp_valid)
            hit_stall <= hit_stall + 1;
         if (stall && flush)
            hit_flush_stall <= hit_flush_stall + 1;
         if (!in_valid && !stall && !flush)
            hit_idle <= hit_idle + 1;
         if (in_valid && !stall && !flush && dec[7])
            hit_illegal <= hit_illegal + 1;
      end
   end

   a_slot_valid: assert property (@(posedge clk) disable iff (!arst_n) out_valid == exp_valid)
      else check_failed("slot_valid", 32'($sampled(exp_valid)), 32'($sampled(out_valid)));

   a_illegal: assert property (@(posedge clk) disable iff (!arst_n) illegal_out == exp_illegal)
      else check_failed("illegal_flag", 32'($sampled(exp_illegal)), 32'($sampled(illegal_out)));

   // Squashing of empty and illegal slots falls out of the same compare
   a_controls: assert property (@(posedge clk) disable iff (!arst_n)
      {reg_write_out, mem_read_out, mem_write_out, mem_to_reg_out, alu_src_out, branch_out,
       jump_out} == exp_ctrl)
      else check_failed("control_decode", 32'($sampled(exp_ctrl)),
                        32'($sampled({reg_write_out, mem_read_out, mem_write_out,
                                      mem_to_reg_out, alu_src_out, branch_out, jump_out})));

   a_imm: assert property (@(posedge clk) disable iff (!arst_n)
      !exp_valid || imm_out == exp_imm)
      else check_failed("immediate", $sampled(exp_imm), $sampled(imm_out));

   // The ALU choice of an illegal word is left open
   a_alu_op: assert property (@(posedge clk) disable iff (!arst_n)
      !exp_valid || exp_illegal || alu_op == exp_alu_op)
      else check_failed("alu_op", 32'($sampled(exp_alu_op)), 32'($sampled(alu_op)));

   a_reg_idx: assert property (@(posedge clk) disable iff (!arst_n)
      !exp_valid || {rs1_out, rs2_out, rd_out} == {exp_rs1, exp_rs2, exp_rd})
      else check_failed("reg_indices", 32'($sampled({exp_rs1, exp_rs2, exp_rd})),
                        32'($sampled({rs1_out, rs2_out, rd_out})));

   initial
   begin
      #(WATCHDOG_TIME);
      $display("Watchdog expired before the stimulus finished");
      $display("Some tests failed");
      $fatal(1);
   end

   initial
   begin
      logic [31:0] word;
      logic [31:0] sub_word;
      logic [31:0] v_bits;
      logic [31:0] s_bits;
      logic [31:0] f_bits;
      lfsr_state      = 32'h5048_b357;
      sub_word        = {F7_ALT, 5'd3, 5'd2, F3_ADD, 5'd1, OPC_OP};
      arst_n   <= 1'b0;
      in_valid <= 1'b0;
      stall    <= 1'b0;
      flush    <= 1'b0;
      instr    <= '0;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
      // Capture a SUB, hold it over a changing input, then flush during the stall
      drive_cycle(1'b1, 1'b0, 1'b0, sub_word);
      repeat (3) drive_cycle(1'b1, 1'b1, 1'b0, 32'hFFFF_FFFF);
      drive_cycle(1'b1, 1'b1, 1'b1, 32'hFFFF_FFFF);
      drive_cycle(1'b0, 1'b0, 1'b0, 32'hFFFF_FFFF);
      drive_cycle(1'b1, 1'b0, 1'b0, 32'hFFFF_FFFF);
      drive_cycle(1'b0, 1'b0, 1'b0, '0);
      for (int c = 0; c < N_RANDOM; c++)
      begin
         make_instr(word);
         rand_bits(3, v_bits);
         rand_bits(3, s_bits);
         rand_bits(4, f_bits);
         drive_cycle(v_bits[2:0] != 3'd0, s_bits[2:0] == 3'd0, f_bits[3:0] == 4'd0, word);
      end
      drive_cycle(1'b0, 1'b0, 1'b0, '0);
      drive_cycle(1'b0, 1'b0, 1'b0, '0);
      @(posedge clk);
      if (hit_stall == 0 || hit_flush_stall == 0 || hit_idle == 0 || hit_illegal == 0)
      begin
         $display("Stimulus never reached a stall, flush during stall, idle or illegal slot");
         $display("Some tests failed");
         $fatal(1);
      end
      else
      begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

/* verilog/decode_unit.sv */
module decode_unit
(
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          in_valid,
   input  logic                          stall,
   input  logic                          flush,
   input  logic [isa_pkg::XLEN-1:0]      instr,
   output logic                          out_valid,
   output logic                          illegal_out,
   output logic                          reg_write_out,
   output logic                          mem_read_out,
   output logic                          mem_write_out,
   output logic                          mem_to_reg_out,
   output logic                          alu_src_out,
   output logic                          branch_out,
   output logic                          jump_out,
   output ctrl_pkg::alu_op_e             alu_op,
   output logic [isa_pkg::XLEN-1:0]      imm_out,
   output logic [isa_pkg::REG_W-1:0]     rs1_out,
   output logic [isa_pkg::REG_W-1:0]     rs2_out,
   output logic [isa_pkg::REG_W-1:0]     rd_out
);

   import isa_pkg::*;
   import ctrl_pkg::*;

   instr_u            instr_w;
   logic              reg_write;
   logic              mem_read;
   logic              mem_write;
   logic              mem_to_reg;
   logic              alu_src;
   logic              branch;
   logic              jump;
   logic              illegal;
   alu_class_e        alu_class;
   logic [XLEN-1:0]   imm;

   // The fetch word is reinterpreted, field positions come from the R view
   assign instr_w = instr;

   // Opcode alone decides the control levels
   main_control u_ctrl
   (
      .opcode     (instr_w.r_fmt.opcode),
      .reg_write  (reg_write),
      .mem_read   (mem_read),
      .mem_write  (mem_write),
      .mem_to_reg (mem_to_reg),
      .alu_src    (alu_src),
      .branch     (branch),
      .jump       (jump),
      .alu_class  (alu_class),
      .illegal    (illegal)
   );

   // The immediate generator needs the whole word since its bits are scattered
   imm_gen u_imm
   (
      .instr (instr_w),
      .imm   (imm)
   );

   // Register indices and funct fields bypass the decoders straight into the stage
   id_ex_stage u_stage
   (
      .clk            (clk),
      .arst_n         (arst_n),
      .in_valid       (in_valid),
      .stall          (stall),
      .flush          (flush),
      .reg_write      (reg_write),
      .mem_read       (mem_read),
      .mem_write      (mem_write),
      .mem_to_reg     (mem_to_reg),
      .alu_src        (alu_src),
      .branch         (branch),
      .jump           (jump),
      .alu_class      (alu_class),
      .illegal        (illegal),
      .imm            (imm),
      .funct3         (instr_w.r_fmt.funct3),
      .funct7         (instr_w.r_fmt.funct7),
      .rs1            (instr_w.r_fmt.rs1),
      .rs2            (instr_w.r_fmt.rs2),
      .rd             (instr_w.r_fmt.rd),
      .out_valid      (out_valid),
      .illegal_out    (illegal_out),
      .reg_write_out  (reg_write_out),
      .mem_read_out   (mem_read_out),
      .mem_write_out  (mem_write_out),
      .mem_to_reg_out (mem_to_reg_out),
      .alu_src_out    (alu_src_out),
      .branch_out     (branch_out),
      .jump_out       (jump_out),
      .alu_op         (alu_op),
      .imm_out        (imm_out),
      .rs1_out        (rs1_out),
      .rs2_out        (rs2_out),
      .rd_out         (rd_out)
   );

endmodule

/* verilog/id_ex_stage.sv */
module id_ex_stage
(
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          in_valid,
   input  logic                          stall,
   input  logic                          flush,
   input  logic                          reg_write,
   input  logic                          mem_read,
   input  logic                          mem_write,
   input  logic                          mem_to_reg,
   input  logic                          alu_src,
   input  logic                          branch,
   input  logic                          jump,
   input  ctrl_pkg::alu_class_e          alu_class,
   input  logic                          illegal,
   input  logic [isa_pkg::XLEN-1:0]      imm,
   input  logic [isa_pkg::F3_W-1:0]      funct3,
   input  logic [isa_pkg::F7_W-1:0]      funct7,
   input  logic [isa_pkg::REG_W-1:0]     rs1,
   input  logic [isa_pkg::REG_W-1:0]     rs2,
   input  logic [isa_pkg::REG_W-1:0]     rd,
   output logic                          out_valid,
   output logic                          illegal_out,
   output logic                          reg_write_out,
   output logic                          mem_read_out,
   output logic                          mem_write_out,
   output logic                          mem_to_reg_out,
   output logic                          alu_src_out,
   output logic                          branch_out,
   output logic                          jump_out,
   output ctrl_pkg::alu_op_e             alu_op,
   output logic [isa_pkg::XLEN-1:0]      imm_out,
   output logic [isa_pkg::REG_W-1:0]     rs1_out,
   output logic [isa_pkg::REG_W-1:0]     rs2_out,
   output logic [isa_pkg::REG_W-1:0]     rd_out
);

   import isa_pkg::*;
   import ctrl_pkg::*;

   logic    f7_alt;
   logic    ctrl_live;
   alu_op_e alu_op_nxt;

   // Controls only pass for a present and legal instruction
   assign ctrl_live = in_valid && !illegal;
   assign f7_alt    = (funct7 == F7_ALT);

   always_comb
   begin
      alu_op_nxt = ADD;
      case (alu_class)
         ALU_ADD:
         begin
            alu_op_nxt = ADD;
         end
         ALU_BR:
         begin
            // funct3[2:1] groups BEQ/BNE, BLT/BGE and BLTU/BGEU
            if (funct3[2:1] == 2'b00)
               alu_op_nxt = SUB;
            else if (funct3[2:1] == 2'b10)
               alu_op_nxt = SLT;
            else
               alu_op_nxt = SLTU;
         end
         default:
         begin
            // ALU_REG and ALU_IMM share the funct3 map
            // ADDI has no SUB twin because its funct7 bits belong to the immediate
            case (funct3)
               F3_ADD:  alu_op_nxt = (alu_class == ALU_REG && f7_alt) ? SUB : ADD;
               F3_SLL:  alu_op_nxt = SLL;
               F3_SLT:  alu_op_nxt = SLT;
               F3_SLTU: alu_op_nxt = SLTU;
               F3_XOR:  alu_op_nxt = XOR;
               F3_SR:   alu_op_nxt = f7_alt ? SRA : SRL;
               F3_OR:   alu_op_nxt = OR;
               F3_AND:  alu_op_nxt = AND;
               default: alu_op_nxt = ADD;
            endcase
         end
      endcase
   end

   // Slot validity and masked controls
   // Flush empties the slot even while execute is stalled
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         out_valid      <= 1'b0;
         illegal_out    <= 1'b0;
         reg_write_out  <= 1'b0;
         mem_read_out   <= 1'b0;
         mem_write_out  <= 1'b0;
         mem_to_reg_out <= 1'b0;
         alu_src_out    <= 1'b0;
         branch_out     <= 1'b0;
         jump_out       <= 1'b0;
      end
      else if (flush)
      begin
         out_valid      <= 1'b0;
         illegal_out    <= 1'b0;
         reg_write_out  <= 1'b0;
         mem_read_out   <= 1'b0;
         mem_write_out  <= 1'b0;
         mem_to_reg_out <= 1'b0;
         alu_src_out    <= 1'b0;
         branch_out     <= 1'b0;
         jump_out       <= 1'b0;
      end
      else if (!stall)
      begin
         // An illegal word still occupies the slot so execute can trap on it
         out_valid      <= in_valid;
         illegal_out    <= in_valid && illegal;
         reg_write_out  <= reg_write && ctrl_live;
         mem_read_out   <= mem_read && ctrl_live;
         mem_write_out  <= mem_write && ctrl_live;
         mem_to_reg_out <= mem_to_reg && ctrl_live;
         alu_src_out    <= alu_src && ctrl_live;
         branch_out     <= branch && ctrl_live;
         jump_out       <= jump && ctrl_live;
      end
   end

   // Operands and ALU choice only matter while out_valid is high
   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         alu_op  <= alu_op_nxt;
         imm_out <= imm;
         rs1_out <= rs1;
         rs2_out <= rs2;
         rd_out  <= rd;
      end
   end

   // An empty slot never writes, accesses memory or redirects fetch
   a_empty_slot_quiet: assert property (@(posedge clk) disable iff (!arst_n)
      !out_valid |-> !(reg_write_out || mem_read_out || mem_write_out || branch_out || jump_out));

   // Execute sees the same instruction for as long as it stalls
   a_stall_holds: assert property (@(posedge clk) disable iff (!arst_n)
      (stall && !flush) |=> $stable({out_valid, illegal_out, reg_write_out, mem_read_out,
                                     mem_write_out, mem_to_reg_out, alu_src_out, branch_out,
                                     jump_out, alu_op, imm_out, rs1_out, rs2_out, rd_out}));

endmodule

/* verilog/imm_gen.sv */
module imm_gen
(
   input  isa_pkg::instr_u              instr,
   output logic [isa_pkg::XLEN-1:0]     imm
);

   import isa_pkg::*;

   always_comb
   begin
      // Opcode bits are in the same place in every view
      case (instr.i_fmt.opcode)
         OPC_OP_IMM, OPC_LOAD, OPC_JALR:
         begin
            // Twelve contiguous bits at the top of the word
            imm = {{(XLEN-12){instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
         end
         OPC_STORE:
         begin
            // Upper seven bits sit above rs2, lower five where rd would be
            imm = {{(XLEN-12){instr.s_fmt.imm_11_5[6]}},
                   instr.s_fmt.imm_11_5,
                   instr.s_fmt.imm_4_0};
         end
         OPC_BRANCH:
         begin
            // Offsets count half-words, so bit 0 is implied zero
            imm = {{(XLEN-13){instr.b_fmt.imm_12}},
                   instr.b_fmt.imm_12,
                   instr.b_fmt.imm_11,
                   instr.b_fmt.imm_10_5,
                   instr.b_fmt.imm_4_1,
                   1'b0};
         end
         default:
         begin
            // R-type carries no immediate and illegal words get none either
            imm = '0;
         end
      endcase
   end

   // Branch targets stay half-word aligned whatever bits the word holds
   always_comb
   begin
      if (instr.b_fmt.opcode == OPC_BRANCH)
      begin
         assert final (imm[0] == 1'b0)
            else $error("imm_gen: branch offset %h is odd", imm);
      end
   end

endmodule

/* verilog/main_control.sv */
module main_control
(
   input  logic [isa_pkg::OPC_W-1:0] opcode,
   output logic                      reg_write,
   output logic                      mem_read,
   output logic                      mem_write,
   output logic                      mem_to_reg,
   output logic                      alu_src,
   output logic                      branch,
   output logic                      jump,
   output ctrl_pkg::alu_class_e      alu_class,
   output logic                      illegal
);

   import isa_pkg::*;
   import ctrl_pkg::*;

   always_comb
   begin
      // Everything starts low so each opcode only raises what it needs
      reg_write  = 1'b0;
      mem_read   = 1'b0;
      mem_write  = 1'b0;
      mem_to_reg = 1'b0;
      alu_src    = 1'b0;
      branch     = 1'b0;
      jump       = 1'b0;
      alu_class  = ALU_ADD;
      illegal    = 1'b0;
      case (opcode)
         OPC_OP:
         begin
            // Both operands come from registers, funct fields pick the operation
            reg_write = 1'b1;
            alu_class = ALU_REG;
         end
         OPC_OP_IMM:
         begin
            // Second operand is the I immediate
            reg_write = 1'b1;
            alu_src   = 1'b1;
            alu_class = ALU_IMM;
         end
         OPC_LOAD:
         begin
            // Address is rs1 plus offset and the result comes back from memory
            reg_write  = 1'b1;
            mem_read   = 1'b1;
            mem_to_reg = 1'b1;
            alu_src    = 1'b1;
            alu_class  = ALU_ADD;
         end
         OPC_STORE:
         begin
            // No register result, rs2 travels on as store data
            mem_write = 1'b1;
            alu_src   = 1'b1;
            alu_class = ALU_ADD;
         end
         OPC_BRANCH:
         begin
            // The ALU compares rs1 with rs2, the target adder lives elsewhere
            branch    = 1'b1;
            alu_class = ALU_BR;
         end
         OPC_JALR:
         begin
            // Target is rs1 plus offset, rd receives the link address
            jump      = 1'b1;
            reg_write = 1'b1;
            alu_src   = 1'b1;
            alu_class = ALU_ADD;
         end
         default:
         begin
            // Unknown opcodes keep every control low and are only flagged
            illegal = 1'b1;
         end
      endcase
   end

   // A single opcode never drives both memory strobes
   always_comb
   begin
      assert final (!(mem_read && mem_write))
         else $error("main_control: load and store strobes both set for opcode %b", opcode);
   end

   // An illegal opcode must leave no trace in the register file or memory
   always_comb
   begin
      assert final (!illegal || !(reg_write || mem_write || jump || branch))
         else $error("main_control: illegal opcode %b still writes state", opcode);
   end

endmodule

/* verilog/ctrl_pkg.sv */
package ctrl_pkg;

   // Widths of the two control encodings
   localparam int ALU_CLASS_W = 2;
   localparam int ALU_OP_W    = 4;

   // Coarse ALU class chosen by the main control decoder
   // ALU_ADD computes an address, ALU_BR compares two registers
   // ALU_REG and ALU_IMM leave the final choice to funct3 and funct7
   typedef enum logic [ALU_CLASS_W-1:0] {
      ALU_ADD = 2'd0,
      ALU_BR  = 2'd1,
      ALU_REG = 2'd2,
      ALU_IMM = 2'd3
   } alu_class_e;

   // Final operation handed to the execute stage
   // SUB doubles as the equality compare for BEQ and BNE
   // SLT and SLTU serve the signed and unsigned branch compares
   typedef enum logic [ALU_OP_W-1:0] {
      ADD  = 4'd0,
      SUB  = 4'd1,
      SLL  = 4'd2,
      SLT  = 4'd3,
      SLTU = 4'd4,
      XOR  = 4'd5,
      SRL  = 4'd6,
      SRA  = 4'd7,
      OR   = 4'd8,
      AND  = 4'd9
   } alu_op_e;

endpackage

/* verilog/isa_pkg.sv */
package isa_pkg;

   // Data word width of the base integer ISA
   localparam int XLEN = 32;

   // Field widths shared by every instruction format
   localparam int OPC_W = 7;
   localparam int F3_W  = 3;
   localparam int F7_W  = 7;
   localparam int REG_W = 5;

   // Major opcodes that this decode stage understands
   localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;
   localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [OPC_W-1:0] OPC_LOAD   = 7'b0000011;
   localparam logic [OPC_W-1:0] OPC_STORE  = 7'b0100011;
   localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;
   localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;

   // Funct3 codes of the integer ALU operations
   // F3_SR covers both SRL and SRA, funct7 tells them apart
   localparam logic [F3_W-1:0] F3_ADD  = 3'b000;
   localparam logic [F3_W-1:0] F3_SLL  = 3'b001;
   localparam logic [F3_W-1:0] F3_SLT  = 3'b010;
   localparam logic [F3_W-1:0] F3_SLTU = 3'b011;
   localparam logic [F3_W-1:0] F3_XOR  = 3'b100;
   localparam logic [F3_W-1:0] F3_SR   = 3'b101;
   localparam logic [F3_W-1:0] F3_OR   = 3'b110;
   localparam logic [F3_W-1:0] F3_AND  = 3'b111;

   // Funct7 value that turns ADD into SUB and SRL into SRA
   localparam logic [F7_W-1:0] F7_ALT = 7'b0100000;

   // Register-register format
   typedef struct packed {
      logic [F7_W-1:0]  funct7;
      logic [REG_W-1:0] rs2;
      logic [REG_W-1:0] rs1;
      logic [F3_W-1:0]  funct3;
      logic [REG_W-1:0] rd;
      logic [OPC_W-1:0] opcode;
   } r_fmt_t;

   // Immediate format used by OP-IMM, loads and JALR
   typedef struct packed {
      logic [11:0]      imm_11_0;
      logic [REG_W-1:0] rs1;
      logic [F3_W-1:0]  funct3;
      logic [REG_W-1:0] rd;
      logic [OPC_W-1:0] opcode;
   } i_fmt_t;

   // Store format, the immediate is split around rs2 and rs1
   typedef struct packed {
      logic [6:0]       imm_11_5;
      logic [REG_W-1:0] rs2;
      logic [REG_W-1:0] rs1;
      logic [F3_W-1:0]  funct3;
      logic [4:0]       imm_4_0;
      logic [OPC_W-1:0] opcode;
   } s_fmt_t;

   // Branch format, bit 11 of the offset sits where the S format keeps bit 0
   typedef struct packed {
      logic             imm_12;
      logic [5:0]       imm_10_5;
      logic [REG_W-1:0] rs2;
      logic [REG_W-1:0] rs1;
      logic [F3_W-1:0]  funct3;
      logic [3:0]       imm_4_1;
      logic             imm_11;
      logic [OPC_W-1:0] opcode;
   } b_fmt_t;

   // One instruction word seen through each format
   typedef union packed {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
      s_fmt_t s_fmt;
      b_fmt_t b_fmt;
   } instr_u;

endpackage
